//--- hdl/arithLane.sv
`default_nettype none

module arithLane (
	input wire logic clock_i,
	input wire logic reset_i,
	input wire logic issue_i,
	input wire busPkg::laneOp_t op_i,
	output busPkg::laneResult_t result_o
);

	// one extra bit to catch the add carry
	logic [isaPkg::DATA_W:0] sumWide;
	isaPkg::data_t aluData;
	isaPkg::status_t aluStatus;
	logic legalOp;
	logic wbValid;

	assign sumWide = {1'b0, op_i.pOperand} + {1'b0, op_i.sOperand};

	////////////////////////////////////////////////////////////////////////////
	// opcode decode and compute
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		aluData = '0;
		aluStatus = '0;
		legalOp = 1'b1;
		case (isaPkg::opcode_e'(op_i.opcode))
			isaPkg::OP_ADD:
			begin
				aluData = sumWide[isaPkg::DATA_W-1:0];
				aluStatus.overflow = sumWide[isaPkg::DATA_W];
			end
			isaPkg::OP_SUB:
			begin
				aluData = op_i.pOperand - op_i.sOperand;
				// borrow out, unsigned compare
				aluStatus.underflow = op_i.pOperand < op_i.sOperand;
			end
			isaPkg::OP_AND: aluData = op_i.pOperand & op_i.sOperand;
			isaPkg::OP_OR: aluData = op_i.pOperand | op_i.sOperand;
			isaPkg::OP_XOR: aluData = op_i.pOperand ^ op_i.sOperand;
			// shift amount is the low nibble only
			isaPkg::OP_SHL: aluData = op_i.pOperand << op_i.sOperand[3:0];
			isaPkg::OP_SHR: aluData = op_i.pOperand >> op_i.sOperand[3:0];
			isaPkg::OP_MOV: aluData = op_i.sOperand;
			default: legalOp = 1'b0;
		endcase
	end

	// illegal opcodes never write back
	assign wbValid = op_i.isWb && legalOp;

	////////////////////////////////////////////////////////////////////////////
	// result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			result_o <= '0;
		end
		else
		begin
			// issued marks the cycle right after the issue strobe
			result_o.issued <= issue_i;
			if (issue_i)
			begin
				result_o.wbValid <= wbValid;
				// non writing lanes leave a clean zero record
				result_o.wbAddr <= wbValid ? op_i.wbAddr : '0;
				result_o.wbData <= wbValid ? aluData : '0;
				result_o.status <= wbValid ? aluStatus : '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/busPkg.sv
`default_nettype none

package busPkg;

	////////////////////////////////////////////////////////////////////////////
	// issue side records
	////////////////////////////////////////////////////////////////////////////

	// one decoded lane op, operands already resolved to values
	// opcode kept as raw bits so illegal codes can travel
	typedef struct packed {
		logic isWb;
		logic [isaPkg::OPCODE_W-1:0] opcode;
		isaPkg::regAddr_t wbAddr;
		isaPkg::data_t pOperand;
		isaPkg::data_t sOperand;
	} laneOp_t;

	// lane A in the upper half
	typedef struct packed {
		laneOp_t laneA;
		laneOp_t laneB;
	} bundle_t;

	////////////////////////////////////////////////////////////////////////////
	// result side records
	////////////////////////////////////////////////////////////////////////////

	// issued is a one cycle marker from the lane register
	typedef struct packed {
		logic issued;
		logic wbValid;
		isaPkg::regAddr_t wbAddr;
		isaPkg::data_t wbData;
		isaPkg::status_t status;
	} laneResult_t;

	// one lane's share of a commit, all zero when not writing
	typedef struct packed {
		logic wbValid;
		isaPkg::regAddr_t wbAddr;
		isaPkg::data_t wbData;
		isaPkg::status_t status;
	} commitHalf_t;

	// lane A in the upper half, same as the bundle
	typedef struct packed {
		commitHalf_t laneA;
		commitHalf_t laneB;
	} commit_t;

endpackage

`default_nettype wire

//--- hdl/commitMerge.sv
`default_nettype none

module commitMerge #(
	parameter int COMMIT_DEPTH = 4,
	parameter int COMMIT_CREDITS = 2
) (
	input wire logic clock_i,
	input wire logic reset_i,
	input wire busPkg::laneResult_t resultA_i,
	input wire busPkg::laneResult_t resultB_i,
	input wire logic commitCredit_i,
	output logic issueReady_o,
	output logic commitValid_o,
	output busPkg::commit_t commit_o
);

	localparam int CNT_W = $clog2(COMMIT_DEPTH + 1);
	localparam int CREDIT_W = (COMMIT_CREDITS > 0) ? $clog2(COMMIT_CREDITS + 1) : 1;
	// one bundle in the queue output register, one in the lanes, one arriving
	localparam int ISSUE_SLACK = 3;

	busPkg::commitHalf_t halfA;
	busPkg::commitHalf_t halfB;
	busPkg::commit_t mergedRecord;
	logic sameDest;
	logic bundleDone;
	logic [CNT_W-1:0] commitCount;
	logic [CREDIT_W-1:0] creditCount;
	logic creditAvail;
	logic commitPop;

	////////////////////////////////////////////////////////////////////////////
	// in-bundle writeback rule
	////////////////////////////////////////////////////////////////////////////

	// both lanes aiming at one register, lane B wins
	assign sameDest = resultA_i.wbValid && resultB_i.wbValid
		&& (resultA_i.wbAddr == resultB_i.wbAddr);

	always_comb
	begin
		halfA.wbValid = resultA_i.wbValid;
		halfA.wbAddr = resultA_i.wbAddr;
		halfA.wbData = resultA_i.wbData;
		halfA.status = resultA_i.status;
		// suppressed lane A looks like a lane that never wrote
		if (sameDest)
		begin
			halfA = '0;
		end
	end

	assign halfB.wbValid = resultB_i.wbValid;
	assign halfB.wbAddr = resultB_i.wbAddr;
	assign halfB.wbData = resultB_i.wbData;
	assign halfB.status = resultB_i.status;

	assign mergedRecord.laneA = halfA;
	assign mergedRecord.laneB = halfB;

	// lanes run in lockstep, both issued in the same cycle
	assign bundleDone = resultA_i.issued && resultB_i.issued;

	////////////////////////////////////////////////////////////////////////////
	// commit queue and downstream credits
	////////////////////////////////////////////////////////////////////////////

	assign creditAvail = creditCount != '0;
	// same condition the queue uses to pop
	assign commitPop = creditAvail && (commitCount != '0);

	creditFifo #(
		.DEPTH(COMMIT_DEPTH),
		.ITEM_T(busPkg::commit_t)
	) commitQueue (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.push_i(bundleDone),
		.item_i(mergedRecord),
		.ready_i(creditAvail),
		.outValid_o(commitValid_o),
		.item_o(commit_o),
		.count_o(commitCount)
	);

	// spent at the pop edge, not at the strobe
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			creditCount <= CREDIT_W'(COMMIT_CREDITS);
		end
		else
		begin
			case ({commitPop, commitCredit_i})
				2'b10: creditCount <= creditCount - 1'b1;
				2'b01: creditCount <= creditCount + 1'b1;
				default: creditCount <= creditCount;
			endcase
		end
	end

	// hold the bundle queue unless three commit slots are free
	assign issueReady_o = (int'(commitCount) + ISSUE_SLACK) <= COMMIT_DEPTH;

endmodule

`default_nettype wire

//--- hdl/creditFifo.sv
`default_nettype none

module creditFifo #(
	parameter int DEPTH = 4,
	parameter type ITEM_T = logic
) (
	input wire logic clock_i,
	input wire logic reset_i,
	input wire logic push_i,
	input wire ITEM_T item_i,
	input wire logic ready_i,
	output logic outValid_o,
	output ITEM_T item_o,
	output logic [$clog2(DEPTH+1)-1:0] count_o
);

	localparam int CNT_W = $clog2(DEPTH + 1);
	// keep at least one pointer bit for a single entry queue
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	ITEM_T mem [DEPTH];
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic doPop;
	logic doPush;

	// deliver whenever the consumer is ready and something is stored
	assign doPop = ready_i && (count_o != '0);
	// a full queue still takes a push on a pop edge
	assign doPush = push_i && ((count_o != CNT_W'(DEPTH)) || doPop);

	////////////////////////////////////////////////////////////////////////////
	// storage and output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (doPush)
		begin
			mem[wrPtr] <= item_i;
		end
		// oldest entry, held until the next delivery
		if (doPop)
		begin
			item_o <= mem[rdPtr];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pointers, occupancy, strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count_o <= '0;
			outValid_o <= 1'b0;
		end
		else
		begin
			// strobe for exactly the cycle after the pop edge
			outValid_o <= doPop;
			if (doPush)
			begin
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			// push and pop together leave the count alone
			case ({doPush, doPop})
				2'b10: count_o <= count_o + 1'b1;
				2'b01: count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

	////////////////////////////////////////////////////////////////////////////
	// datapath widths
	////////////////////////////////////////////////////////////////////////////

	// operand and result width
	localparam int DATA_W = 16;
	// destination register address width, 32 registers
	localparam int REG_ADDR_W = 5;
	// opcode field width as it comes out of decode
	localparam int OPCODE_W = 7;

	////////////////////////////////////////////////////////////////////////////
	// arithmetic opcodes
	////////////////////////////////////////////////////////////////////////////

	// zero and anything above OP_MOV are illegal
	typedef enum logic [OPCODE_W-1:0] {
		OP_ADD = 7'd1,
		OP_SUB = 7'd2,
		OP_AND = 7'd3,
		OP_OR  = 7'd4,
		OP_XOR = 7'd5,
		OP_SHL = 7'd6,
		OP_SHR = 7'd7,
		OP_MOV = 7'd8
	} opcode_e;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [REG_ADDR_W-1:0] regAddr_t;

	// two status bits per lane, overflow in the upper bit
	typedef struct packed {
		logic overflow;
		logic underflow;
	} status_t;

endpackage

`default_nettype wire

//--- hdl/vliwExecCore.sv
`default_nettype none

module vliwExecCore #(
	parameter int BUNDLE_DEPTH = 4,
	parameter int COMMIT_DEPTH = 4,
	parameter int COMMIT_CREDITS = 2
) (
	input wire logic clock_i,
	input wire logic reset_i,
	input wire logic bundleValid_i,
	input wire busPkg::bundle_t bundle_i,
	output wire logic bundleCredit_o,
	input wire logic commitCredit_i,
	output wire logic commitValid_o,
	output wire busPkg::commit_t commit_o
);

	// bundle queue out, lanes in
	logic issueStrobe;
	busPkg::bundle_t issuedBundle;
	// commit merger back pressure
	logic issueReady;
	// lanes out, merger in
	busPkg::laneResult_t resultA;
	busPkg::laneResult_t resultB;

	////////////////////////////////////////////////////////////////////////////
	// bundle queue, sized to the upstream credits
	////////////////////////////////////////////////////////////////////////////

	creditFifo #(
		.DEPTH(BUNDLE_DEPTH),
		.ITEM_T(busPkg::bundle_t)
	) bundleQueue (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.push_i(bundleValid_i),
		.item_i(bundle_i),
		.ready_i(issueReady),
		.outValid_o(issueStrobe),
		.item_o(issuedBundle),
		.count_o()
	);

	// each bundle leaving the queue hands one credit back
	assign bundleCredit_o = issueStrobe;

	////////////////////////////////////////////////////////////////////////////
	// lanes
	////////////////////////////////////////////////////////////////////////////

	arithLane laneA (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.issue_i(issueStrobe),
		.op_i(issuedBundle.laneA),
		.result_o(resultA)
	);

	arithLane laneB (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.issue_i(issueStrobe),
		.op_i(issuedBundle.laneB),
		.result_o(resultB)
	);

	// merge, commit queue, downstream credits
	commitMerge #(
		.COMMIT_DEPTH(COMMIT_DEPTH),
		.COMMIT_CREDITS(COMMIT_CREDITS)
	) merger (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.resultA_i(resultA),
		.resultB_i(resultB),
		.commitCredit_i(commitCredit_i),
		.issueReady_o(issueReady),
		.commitValid_o(commitValid_o),
		.commit_o(commit_o)
	);

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module vliwExecTb -o vliwExecSim \
	&& {
		simOut="$(./obj_dir/vliwExecSim 2>&1)"
		printf '%s\n' "$simOut"
		printf '%s\n' "$simOut" | grep -qF "Result: PASSED"
	} \
	&& echo "simulation run succeeded" \
	|| { echo "simulation run failed"; exit 1; }

//--- verification/vliwExecCore_assert.sv
`default_nettype none

module vliwExecCore_assert #(
	parameter int COMMIT_DEPTH = 4,
	parameter int CNT_W = 3,
	parameter int CREDIT_W = 2
) (
	input wire logic clock_i,
	input wire logic reset_i,
	input wire busPkg::laneResult_t resultA_i,
	input wire busPkg::laneResult_t resultB_i,
	input wire logic commitValid_i,
	input wire logic [CREDIT_W-1:0] creditCount_i,
	input wire logic [CNT_W-1:0] commitCount_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// lanes share one issue strobe
	laneLockstep: assert property (@(posedge clock_i) disable iff (reset_i)
		resultA_i.issued == resultB_i.issued)
		else $error("lane A and lane B issue markers differ");

	// credit is spent at the pop edge, one cycle before the strobe
	creditBacked: assert property (@(posedge clock_i) disable iff (reset_i)
		commitValid_i |-> $past(creditCount_i) != '0)
		else $error("commit strobe without a downstream credit");

	queueBound: assert property (@(posedge clock_i) disable iff (reset_i)
		int'(commitCount_i) <= COMMIT_DEPTH)
		else $error("commit queue occupancy above its depth");

endmodule

bind commitMerge vliwExecCore_assert #(
	.COMMIT_DEPTH(COMMIT_DEPTH),
	.CNT_W(CNT_W),
	.CREDIT_W(CREDIT_W)
) u_commitMergeAssert (
	.clock_i(clock_i),
	.reset_i(reset_i),
	.resultA_i(resultA_i),
	.resultB_i(resultB_i),
	.commitValid_i(commitValid_o),
	.creditCount_i(creditCount),
	.commitCount_i(commitCount)
);

`default_nettype wire

//--- verification/vliwExecTb.sv
`default_nettype none

module vliwExecTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BUNDLE_DEPTH = 4;
	localparam int COMMIT_DEPTH = 4;
	localparam int COMMIT_CREDITS = 2;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 24;
	// data file columns per bundle
	localparam int WORDS = 18;
	// commit credits withheld for a while once this many commits are in
	localparam int HOLD_AT = 8;
	localparam int HOLD_CYCLES = 30;
	localparam logic [31:0] SEED = 32'h98e01971;
	localparam int CMP_W = $bits(busPkg::commit_t);

	logic clock_i = 1'b0;
	logic reset_i = 1'b1;
	logic bundleValid_i = 1'b0;
	busPkg::bundle_t bundle_i = '0;
	logic commitCredit_i = 1'b0;
	logic bundleCredit_o;
	logic commitValid_o;
	busPkg::commit_t commit_o;

	logic [31:0] testMem [NUM_TESTS*WORDS];
	int commitIdx = 0;
	logic runPassed = 1'b0;
	logic failReported = 1'b0;

	vliwExecCore #(
		.BUNDLE_DEPTH(BUNDLE_DEPTH),
		.COMMIT_DEPTH(COMMIT_DEPTH),
		.COMMIT_CREDITS(COMMIT_CREDITS)
	) u_vliwExecCore (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.bundleValid_i(bundleValid_i),
		.bundle_i(bundle_i),
		.bundleCredit_o(bundleCredit_o),
		.commitCredit_i(commitCredit_i),
		.commitValid_o(commitValid_o),
		.commit_o(commit_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// five columns per lane op
	function automatic busPkg::laneOp_t unpackOp(input int base);
		busPkg::laneOp_t op;
		op.isWb = testMem[base][0];
		op.opcode = testMem[base+1][6:0];
		op.wbAddr = testMem[base+2][4:0];
		op.pOperand = testMem[base+3][15:0];
		op.sOperand = testMem[base+4][15:0];
		return op;
	endfunction

	// four columns per expected commit half
	function automatic busPkg::commitHalf_t unpackHalf(input int base);
		busPkg::commitHalf_t half;
		half.wbValid = testMem[base][0];
		half.wbAddr = testMem[base+1][4:0];
		half.wbData = testMem[base+2][15:0];
		half.status = testMem[base+3][1:0];
		return half;
	endfunction

	function automatic busPkg::bundle_t bundleFor(input int t);
		busPkg::bundle_t b;
		b.laneA = unpackOp(t*WORDS);
		b.laneB = unpackOp(t*WORDS + 5);
		return b;
	endfunction

	function automatic busPkg::commit_t expectedFor(input int t);
		busPkg::commit_t c;
		c.laneA = unpackHalf(t*WORDS + 10);
		c.laneB = unpackHalf(t*WORDS + 14);
		return c;
	endfunction

	task automatic showFailure();
		failReported = 1'b1;
		$display("Result: FAILED");
	endtask

	task automatic abortRun();
		showFailure();
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [CMP_W-1:0] expected,
		input logic [CMP_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// clock, watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		forever #5 clock_i = ~clock_i;
	end

	// forty cycles per bundle covers the withheld credit window
	initial
	begin
		repeat (RESET_CYCLES + NUM_TESTS*40) @(posedge clock_i);
		$display("timeout: not every bundle produced its commit in time");
		abortRun();
	end

	// a stop from a failed assertion skips both tasks above
	final
	begin
		if (!runPassed && !failReported)
		begin
			$display("run ended before the testbench finished its checks");
			showFailure();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// upstream side, bundles against credits
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int sent;
		int credits;
		int pulses;
		sent = 0;
		credits = BUNDLE_DEPTH;
		pulses = 0;
		$readmemh("verification/vliwExecTests.txt", testMem);
		repeat (RESET_CYCLES) @(posedge clock_i);
		#1;
		reset_i = 1'b0;
		while (commitIdx < NUM_TESTS)
		begin
			// credit strobe is stable one ns past the edge
			if (bundleCredit_o)
			begin
				credits++;
				pulses++;
			end
			if (credits > BUNDLE_DEPTH)
			begin
				$display("more bundle credits came back than bundles were sent");
				abortRun();
			end
			if (sent < NUM_TESTS && credits > 0)
			begin
				bundle_i = bundleFor(sent);
				bundleValid_i = 1'b1;
				sent++;
				credits--;
			end
			else
			begin
				bundleValid_i = 1'b0;
			end
			@(posedge clock_i);
			#1;
		end
		// late pulses and stray commits
		repeat (10)
		begin
			@(posedge clock_i);
			#1;
			if (bundleCredit_o)
			begin
				pulses++;
			end
		end
		checkValue("bundle credit pulses", CMP_W'(NUM_TESTS), CMP_W'(pulses));
		runPassed = 1'b1;
		$display("Result: PASSED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// downstream side, commit check and credit return
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] seed;
		int tbCredits;
		int owed;
		int holdLeft;
		logic holdDone;
		seed = SEED;
		tbCredits = COMMIT_CREDITS;
		owed = 0;
		holdLeft = 0;
		holdDone = 1'b0;
		@(negedge reset_i);
		forever
		begin
			@(posedge clock_i);
			#1;
			if (commitValid_o)
			begin
				if (commitIdx >= NUM_TESTS)
				begin
					$display("a commit arrived after the last bundle had committed");
					abortRun();
				end
				if (tbCredits == 0)
				begin
					$display("a commit arrived while the consumer held no credit");
					abortRun();
				end
				checkValue($sformatf("test %0d commit", commitIdx), expectedFor(commitIdx),
					commit_o);
				commitIdx++;
				tbCredits--;
				owed++;
			end
			// one long stall to fill the commit queue
			if (!holdDone && commitIdx >= HOLD_AT)
			begin
				holdLeft = HOLD_CYCLES;
				holdDone = 1'b1;
			end
			seed = lcgNext(seed);
			commitCredit_i = 1'b0;
			if (holdLeft > 0)
			begin
				holdLeft--;
			end
			else if (owed > 0 && seed[17:16] != 2'b00)
			begin
				// only hand back what was received
				commitCredit_i = 1'b1;
				owed--;
				tbCredits++;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/vliwExecTests.txt
// lane A then lane B op: isWb opcode wbAddr pOperand sOperand
// then expected commit, lane A then lane B: wbValid wbAddr wbData status (2 ovf, 1 udf)
1 01 01 0003 0004  1 02 02 0010 0003  1 01 0007 0  1 02 000d 0
1 01 03 ffff 0002  1 02 04 0003 0005  1 03 0001 2  1 04 fffe 1
1 03 05 f0f0 0ff0  1 04 06 f000 000f  1 05 00f0 0  1 06 f00f 0
1 05 07 aaaa ffff  1 06 08 0001 0013  1 07 5555 0  1 08 0008 0
1 07 09 8000 0004  1 08 0a 1234 beef  1 09 0800 0  1 0a beef 0
1 01 0b 0001 0001  1 08 0b 0000 5a5a  0 00 0000 0  1 0b 5a5a 0
0 01 0c 0001 0001  1 00 0d 0001 0001  0 00 0000 0  0 00 0000 0
1 09 0e 0001 0001  1 01 0f 8000 8000  0 00 0000 0  1 0f 0000 2
0 08 10 0000 1111  1 08 10 0000 2222  0 00 0000 0  1 10 2222 0
1 01 11 0002 0003  1 7f 11 0001 0001  1 11 0005 0  0 00 0000 0
1 02 12 0005 0005  1 06 13 ffff 000f  1 12 0000 0  1 13 8000 0
1 07 14 ffff 0010  1 06 15 1234 0020  1 14 ffff 0  1 15 1234 0
1 01 16 7fff 0001  1 02 17 0000 0001  1 16 8000 0  1 17 ffff 1
1 08 18 9999 0000  1 05 19 1234 1234  1 18 0000 0  1 19 0000 0
1 03 1a ffff 0000  1 04 1b 0000 0000  1 1a 0000 0  1 1b 0000 0
1 01 1f ffff ffff  1 02 00 ffff 0000  1 1f fffe 2  1 00 ffff 0
1 08 01 0000 0001  1 08 01 0000 0002  0 00 0000 0  1 01 0002 0
1 02 02 0001 ffff  1 01 03 0000 0000  1 02 0002 1  1 03 0000 0
0 02 04 0001 0002  0 01 05 ffff ffff  0 00 0000 0  0 00 0000 0
1 06 06 00ff 0008  1 07 07 00ff 0008  1 06 ff00 0  1 07 0000 0
1 05 08 0f0f 00ff  1 03 09 1234 00ff  1 08 0ff0 0  1 09 0034 0
1 04 0a 1200 0034  1 01 0a 0001 0001  0 00 0000 0  1 0a 0002 0
1 01 0c 1000 2000  1 02 0d 3000 1000  1 0c 3000 0  1 0d 2000 0
1 08 0e 0000 beef  1 08 0f 0000 cafe  1 0e beef 0  1 0f cafe 0

//--- vlog.f
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/creditFifo.sv
hdl/arithLane.sv
hdl/commitMerge.sv
hdl/vliwExecCore.sv
verification/vliwExecCore_assert.sv
verification/vliwExecTb.sv
